// File: hw/soc_defines.svh
// soc peripheral subsystem defines
// widths, address map, register offsets and reset values shared by
// the bus fabric and the slaves
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// data and address width
`define SOC_DATA_W          32

// address bits that pick the slave
`define SOC_SEL_MSB         31
`define SOC_SEL_LSB         28

// register offset field inside a slave window
`define SOC_OFS_MSB         3

// data memory, word addressed
`define SOC_DMEM_DEPTH      256

// gpio
`define SOC_GPIO_PINS       16
`define SOC_GPIO_CTRL_OFS   4'h0
`define SOC_GPIO_DATA_OFS   4'h4
`define SOC_GPIO_MODE_OUT   2'b01
`define SOC_GPIO_MODE_IN    2'b10

// timer registers and ctrl bits
`define SOC_TMR_CTRL_OFS    4'h0
`define SOC_TMR_COUNT_OFS   4'h4
`define SOC_TMR_VALUE_OFS   4'h8
`define SOC_TMR_EN_BIT      0
`define SOC_TMR_IE_BIT      1
`define SOC_TMR_PEND_BIT    2

// value loaded into peripheral registers at reset
`define SOC_REG_RST_VAL     '0

`endif

// File: hw/soc_pkg.sv
// soc bus types
// master and slave request formats and the slave select encoding
`include "soc_defines.svh"

package soc_pkg;

    // --------------------------------------------------------------------------
    // master side request, driven by the core or the debugger
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`SOC_DATA_W-1:0] addr;
        logic [`SOC_DATA_W-1:0] wdata;
    } bus_req_t;

    // --------------------------------------------------------------------------
    // slave side request, one per slave
    // --------------------------------------------------------------------------
    // sel is high only for the slave the decode picked
    typedef struct packed {
        logic                   sel;
        logic                   we;
        logic [`SOC_DATA_W-1:0] addr;
        logic [`SOC_DATA_W-1:0] wdata;
    } slv_req_t;

    // top address nibble, anything not listed is unmapped
    typedef enum logic [`SOC_SEL_MSB-`SOC_SEL_LSB:0] {
        SEL_DMEM  = 4'd0,
        SEL_TIMER = 4'd1,
        SEL_GPIO  = 4'd2
    } slv_sel_e;

endpackage

// File: hw/soc_bus.sv
// soc bus fabric
// fixed priority between the core port (m0) and the debug port (m1),
// address decode to data memory, timer and gpio, and read data return.
// the debug port always wins; the core sees hold while it loses.
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_bus (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // masters
    input  soc_pkg::bus_req_t       m0_req_i,
    output logic [`SOC_DATA_W-1:0]  m0_rdata_o,
    input  soc_pkg::bus_req_t       m1_req_i,
    output logic [`SOC_DATA_W-1:0]  m1_rdata_o,

    // slaves
    output soc_pkg::slv_req_t       dmem_req_o,
    input  logic [`SOC_DATA_W-1:0]  dmem_rdata_i,
    output soc_pkg::slv_req_t       timer_req_o,
    input  logic [`SOC_DATA_W-1:0]  timer_rdata_i,
    output soc_pkg::slv_req_t       gpio_req_o,
    input  logic [`SOC_DATA_W-1:0]  gpio_rdata_i,

    // core stall
    output logic                    hold_o
);

    logic                   m0_grant;
    logic                   m1_grant;
    soc_pkg::bus_req_t      grant_req;
    soc_pkg::slv_sel_e      sel;
    soc_pkg::slv_req_t      base_req;
    logic [`SOC_DATA_W-1:0] slv_rdata;

    // --------------------------------------------------------------------------
    // arbitration
    // --------------------------------------------------------------------------
    // debug port has priority over the core
    assign m1_grant = m1_req_i.req;
    assign m0_grant = m0_req_i.req & ~m1_req_i.req;

    // core has to retry whatever it asked for in this cycle
    assign hold_o = m0_req_i.req & m1_req_i.req;

    assign grant_req = m1_grant ? m1_req_i : m0_req_i;

    // --------------------------------------------------------------------------
    // decode and slave request fan-out
    // --------------------------------------------------------------------------
    assign sel = soc_pkg::slv_sel_e'(grant_req.addr[`SOC_SEL_MSB:`SOC_SEL_LSB]);

    always_comb begin
        // every slave sees the same request, only sel differs
        base_req.sel   = 1'b0;
        base_req.we    = grant_req.we;
        base_req.addr  = grant_req.addr;
        base_req.wdata = grant_req.wdata;

        dmem_req_o  = base_req;
        timer_req_o = base_req;
        gpio_req_o  = base_req;
        slv_rdata   = '0;

        if (grant_req.req) begin
            case (sel)
                soc_pkg::SEL_DMEM: begin
                    dmem_req_o.sel = 1'b1;
                    slv_rdata      = dmem_rdata_i;
                end
                soc_pkg::SEL_TIMER: begin
                    timer_req_o.sel = 1'b1;
                    slv_rdata       = timer_rdata_i;
                end
                soc_pkg::SEL_GPIO: begin
                    gpio_req_o.sel = 1'b1;
                    slv_rdata      = gpio_rdata_i;
                end
                // unmapped, reads zero and writes go nowhere
                default: begin
                    slv_rdata = '0;
                end
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // read data return
    // --------------------------------------------------------------------------
    // only the winner gets data, the loser reads zero
    assign m0_rdata_o = m0_grant ? slv_rdata : '0;
    assign m1_rdata_o = m1_grant ? slv_rdata : '0;

    // never two slaves addressed at once
    assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({dmem_req_o.sel, timer_req_o.sel, gpio_req_o.sel}))
        else $error("soc_bus: more than one slave selected");

endmodule

// File: hw/data_mem.sv
// data memory
// word addressed register array, combinational read and write on the
// rising edge when the bus selects it with we set
`timescale 1ns/1ps
`include "soc_defines.svh"

module data_mem (
    input  logic                    clk,
    input  soc_pkg::slv_req_t       req_i,
    output logic [`SOC_DATA_W-1:0]  rdata_o
);

    localparam int IDX_W = $clog2(`SOC_DMEM_DEPTH);

    logic [`SOC_DATA_W-1:0] mem [`SOC_DMEM_DEPTH];
    logic [IDX_W-1:0]       word_idx;
    logic                   wr_en;

    // byte address to word index, low two bits dropped
    assign word_idx = req_i.addr[IDX_W+1:2];
    assign wr_en    = req_i.sel & req_i.we;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[word_idx] <= req_i.wdata;
        end
    end

    // read is always live, the bus only forwards it when selected
    assign rdata_o = mem[word_idx];

    // masters only issue word aligned accesses
    assert property (@(posedge clk)
        req_i.sel |-> (req_i.addr[1:0] == 2'b00))
        else $error("data_mem: unaligned access at %h", req_i.addr);

endmodule

// File: hw/timer.sv
// timer
// free running counter that wraps at a compare value and raises a
// pending bit; irq follows pending when interrupts are enabled.
// ctrl bit 0 enable, bit 1 int enable, bit 2 pending (write 1 to clear)
`timescale 1ns/1ps
`include "soc_defines.svh"

module timer (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  soc_pkg::slv_req_t       req_i,
    output logic [`SOC_DATA_W-1:0]  rdata_o,
    output logic                    irq_o
);

    logic                   en_q;
    logic                   ie_q;
    logic                   pend_q;
    logic [`SOC_DATA_W-1:0] count_q;
    logic [`SOC_DATA_W-1:0] value_q;
    logic [`SOC_DATA_W-1:0] ctrl_rd;
    logic                   wr_en;
    logic                   ctrl_wr;
    logic                   value_wr;
    logic                   match;

    assign wr_en    = req_i.sel & req_i.we;
    assign ctrl_wr  = wr_en && (req_i.addr[`SOC_OFS_MSB:0] == `SOC_TMR_CTRL_OFS);
    assign value_wr = wr_en && (req_i.addr[`SOC_OFS_MSB:0] == `SOC_TMR_VALUE_OFS);
    assign match    = en_q && (count_q == value_q);

    // --------------------------------------------------------------------------
    // registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            en_q    <= 1'b0;
            ie_q    <= 1'b0;
            pend_q  <= 1'b0;
            count_q <= `SOC_REG_RST_VAL;
            value_q <= `SOC_REG_RST_VAL;
        end else begin
            if (ctrl_wr) begin
                en_q <= req_i.wdata[`SOC_TMR_EN_BIT];
                ie_q <= req_i.wdata[`SOC_TMR_IE_BIT];
            end
            if (value_wr) begin
                value_q <= req_i.wdata;
            end
            if (en_q) begin
                count_q <= match ? '0 : count_q + `SOC_DATA_W'(1);
            end
            // a new match beats a clear in the same cycle
            if (match) begin
                pend_q <= 1'b1;
            end else if (ctrl_wr && req_i.wdata[`SOC_TMR_PEND_BIT]) begin
                pend_q <= 1'b0;
            end
        end
    end

    assign irq_o = pend_q & ie_q;

    // read mux
    always_comb begin
        ctrl_rd                    = '0;
        ctrl_rd[`SOC_TMR_EN_BIT]   = en_q;
        ctrl_rd[`SOC_TMR_IE_BIT]   = ie_q;
        ctrl_rd[`SOC_TMR_PEND_BIT] = pend_q;
        case (req_i.addr[`SOC_OFS_MSB:0])
            `SOC_TMR_CTRL_OFS:  rdata_o = ctrl_rd;
            `SOC_TMR_COUNT_OFS: rdata_o = count_q;
            `SOC_TMR_VALUE_OFS: rdata_o = value_q;
            default:            rdata_o = '0;
        endcase
    end

    // once inside the period, count stays there until value is rewritten
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (en_q && (count_q <= value_q) && !value_wr) |=> (count_q <= value_q))
        else $error("timer: count %h passed value %h", count_q, value_q);

endmodule

// File: hw/gpio.sv
// gpio
// 16 pins, two mode bits per pin (01 output, 10 input), data register
// for the output level and a two flop synchronizer on the inputs
`timescale 1ns/1ps
`include "soc_defines.svh"

module gpio (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  soc_pkg::slv_req_t           req_i,
    output logic [`SOC_DATA_W-1:0]      rdata_o,
    input  logic [`SOC_GPIO_PINS-1:0]   gpio_i,
    output logic [`SOC_GPIO_PINS-1:0]   gpio_oe_o,
    output logic [`SOC_GPIO_PINS-1:0]   gpio_out_o
);

    logic [2*`SOC_GPIO_PINS-1:0] ctrl_q;
    logic [`SOC_GPIO_PINS-1:0]   data_q;
    logic [`SOC_GPIO_PINS-1:0]   sync1_q;
    logic [`SOC_GPIO_PINS-1:0]   sync2_q;
    logic [`SOC_GPIO_PINS-1:0]   pin_rd;
    logic                        wr_en;

    assign wr_en = req_i.sel & req_i.we;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_q <= `SOC_REG_RST_VAL;
            data_q <= `SOC_REG_RST_VAL;
        end else if (wr_en) begin
            if (req_i.addr[`SOC_OFS_MSB:0] == `SOC_GPIO_CTRL_OFS) begin
                ctrl_q <= req_i.wdata[2*`SOC_GPIO_PINS-1:0];
            end
            if (req_i.addr[`SOC_OFS_MSB:0] == `SOC_GPIO_DATA_OFS) begin
                data_q <= req_i.wdata[`SOC_GPIO_PINS-1:0];
            end
        end
    end

    // pins are asynchronous to clk
    always_ff @(posedge clk) begin
        sync1_q <= gpio_i;
        sync2_q <= sync1_q;
    end

    // --------------------------------------------------------------------------
    // per pin mode decode
    // --------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `SOC_GPIO_PINS; i++) begin
            gpio_oe_o[i] = (ctrl_q[2*i +: 2] == `SOC_GPIO_MODE_OUT);
            if (ctrl_q[2*i +: 2] == `SOC_GPIO_MODE_OUT) begin
                pin_rd[i] = data_q[i];
            end else if (ctrl_q[2*i +: 2] == `SOC_GPIO_MODE_IN) begin
                pin_rd[i] = sync2_q[i];
            end else begin
                pin_rd[i] = 1'b0;
            end
        end
    end

    assign gpio_out_o = data_q;

    always_comb begin
        case (req_i.addr[`SOC_OFS_MSB:0])
            `SOC_GPIO_CTRL_OFS: rdata_o = `SOC_DATA_W'(ctrl_q);
            `SOC_GPIO_DATA_OFS: rdata_o = `SOC_DATA_W'(pin_rd);
            default:            rdata_o = '0;
        endcase
    end

    // no pin may be driven once reset has been seen
    assert property (@(posedge clk) !rst_n_i |=> (gpio_oe_o == '0))
        else $error("gpio: output enable %h after reset", gpio_oe_o);

endmodule

// File: hw/soc_top.sv
// soc peripheral subsystem top
// core and debug master ports into the bus fabric, which serves the
// data memory, the timer and the gpio block. pads stay outside, gpio
// is brought out as separate enable, output and input buses.
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_top (
    input  logic                        clk,
    input  logic                        rst_n_i,

    // core data port
    input  soc_pkg::bus_req_t           m0_req_i,
    output logic [`SOC_DATA_W-1:0]      m0_rdata_o,

    // debug port
    input  soc_pkg::bus_req_t           m1_req_i,
    output logic [`SOC_DATA_W-1:0]      m1_rdata_o,

    output logic                        hold_o,
    output logic                        irq_o,

    // gpio pad side
    input  logic [`SOC_GPIO_PINS-1:0]   gpio_i,
    output logic [`SOC_GPIO_PINS-1:0]   gpio_oe_o,
    output logic [`SOC_GPIO_PINS-1:0]   gpio_out_o
);

    soc_pkg::slv_req_t      dmem_req;
    soc_pkg::slv_req_t      timer_req;
    soc_pkg::slv_req_t      gpio_req;
    logic [`SOC_DATA_W-1:0] dmem_rdata;
    logic [`SOC_DATA_W-1:0] timer_rdata;
    logic [`SOC_DATA_W-1:0] gpio_rdata;

    // --------------------------------------------------------------------------
    // bus fabric
    // --------------------------------------------------------------------------
    soc_bus u_bus_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .m0_req_i       ( m0_req_i      ),
        .m0_rdata_o     ( m0_rdata_o    ),
        .m1_req_i       ( m1_req_i      ),
        .m1_rdata_o     ( m1_rdata_o    ),
        .dmem_req_o     ( dmem_req      ),
        .dmem_rdata_i   ( dmem_rdata    ),
        .timer_req_o    ( timer_req     ),
        .timer_rdata_i  ( timer_rdata   ),
        .gpio_req_o     ( gpio_req      ),
        .gpio_rdata_i   ( gpio_rdata    ),
        .hold_o         ( hold_o        )
    );

    // --------------------------------------------------------------------------
    // slaves
    // --------------------------------------------------------------------------
    data_mem u_data_mem_0 (
        .clk            ( clk           ),
        .req_i          ( dmem_req      ),
        .rdata_o        ( dmem_rdata    )
    );

    timer u_timer_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .req_i          ( timer_req     ),
        .rdata_o        ( timer_rdata   ),
        .irq_o          ( irq_o         )
    );

    gpio u_gpio_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .req_i          ( gpio_req      ),
        .rdata_o        ( gpio_rdata    ),
        .gpio_i         ( gpio_i        ),
        .gpio_oe_o      ( gpio_oe_o     ),
        .gpio_out_o     ( gpio_out_o    )
    );

endmodule

// File: test/tb_soc_top.sv
// testbench for the soc peripheral subsystem
// drives the core and debug ports with random traffic and checks every
// cycle against a model of the memory, timer and gpio block
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc_top;

    localparam int CLK_PERIOD = 8;
    localparam int N_MEM      = 400;
    localparam int N_CONFLICT = 60;
    localparam int N_UNMAP    = 40;
    localparam int N_GPIO     = 8;
    localparam int N_TMR      = 6;
    localparam int TOTAL_TXN  = 7 + N_MEM + 2*N_CONFLICT + 3*N_UNMAP + 18*N_GPIO + 50*N_TMR;

    localparam logic [31:0] TMR_CTRL  = {4'h1, 24'h0, `SOC_TMR_CTRL_OFS};
    localparam logic [31:0] TMR_COUNT = {4'h1, 24'h0, `SOC_TMR_COUNT_OFS};
    localparam logic [31:0] TMR_VALUE = {4'h1, 24'h0, `SOC_TMR_VALUE_OFS};
    localparam logic [31:0] GPIO_CTRL = {4'h2, 24'h0, `SOC_GPIO_CTRL_OFS};
    localparam logic [31:0] GPIO_DATA = {4'h2, 24'h0, `SOC_GPIO_DATA_OFS};

    logic                       clk;
    logic                       rst_n_i;
    soc_pkg::bus_req_t          m0_req;
    soc_pkg::bus_req_t          m1_req;
    logic [`SOC_DATA_W-1:0]     m0_rdata;
    logic [`SOC_DATA_W-1:0]     m1_rdata;
    logic                       hold;
    logic                       irq;
    logic [`SOC_GPIO_PINS-1:0]  gpio_i;
    logic [`SOC_GPIO_PINS-1:0]  gpio_oe;
    logic [`SOC_GPIO_PINS-1:0]  gpio_out;

    // model state
    logic [31:0]                mem_m [int];
    int                         written_q [$];
    logic                       m_en;
    logic                       m_ie;
    logic                       m_pend;
    logic [31:0]                m_count;
    logic [31:0]                m_value;
    logic [31:0]                m_ctrl;
    logic [`SOC_GPIO_PINS-1:0]  m_data;
    logic [`SOC_GPIO_PINS-1:0]  m_sync1;
    logic [`SOC_GPIO_PINS-1:0]  m_sync2;
    int                         err_count;
    int                         chk_count;

    soc_top dut0 (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n_i   ),
        .m0_req_i   ( m0_req    ),
        .m0_rdata_o ( m0_rdata  ),
        .m1_req_i   ( m1_req    ),
        .m1_rdata_o ( m1_rdata  ),
        .hold_o     ( hold      ),
        .irq_o      ( irq       ),
        .gpio_i     ( gpio_i    ),
        .gpio_oe_o  ( gpio_oe   ),
        .gpio_out_o ( gpio_out  )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // model
    // ------------------------------------------------------------------------
    // per pin read value, 01 output data, 10 synchronized input, else 0
    function automatic logic [`SOC_GPIO_PINS-1:0] pin_merge();
        logic [`SOC_GPIO_PINS-1:0] v;
        v = '0;
        for (int i = 0; i < `SOC_GPIO_PINS; i++) begin
            if (m_ctrl[2*i +: 2] == 2'b01)
                v[i] = m_data[i];
            else if (m_ctrl[2*i +: 2] == 2'b10)
                v[i] = m_sync2[i];
        end
        return v;
    endfunction

    function automatic logic [`SOC_GPIO_PINS-1:0] oe_expect();
        logic [`SOC_GPIO_PINS-1:0] v;
        for (int i = 0; i < `SOC_GPIO_PINS; i++) begin
            v[i] = (m_ctrl[2*i +: 2] == 2'b01);
        end
        return v;
    endfunction

    // known is cleared for memory words never written
    function automatic logic [31:0] expected_read(input logic [31:0] addr, output bit known);
        logic [31:0] rd;
        rd = '0;
        known = 1'b1;
        case (addr[31:28])
            4'd0: begin
                known = (mem_m.exists(int'(addr[9:2])) != 0);
                if (known)
                    rd = mem_m[int'(addr[9:2])];
            end
            4'd1: rd = (addr[3:0] == `SOC_TMR_COUNT_OFS) ? m_count :
                       (addr[3:0] == `SOC_TMR_VALUE_OFS) ? m_value :
                       {29'd0, m_pend, m_ie, m_en};
            4'd2: rd = (addr[3:0] == `SOC_GPIO_DATA_OFS) ? 32'(pin_merge()) : m_ctrl;
            default: rd = '0;
        endcase
        return rd;
    endfunction

    // one rising edge worth of state change, from the values before the edge
    task automatic advance_model();
        soc_pkg::bus_req_t g;
        logic              match;
        logic [3:0]        ofs;
        g = m1_req.req ? m1_req : m0_req;
        ofs = g.addr[3:0];
        match = m_en && (m_count == m_value);
        if (m_en)
            m_count = match ? 32'd0 : m_count + 32'd1;
        if (match)
            m_pend = 1'b1;
        if (g.req && g.we) begin
            case (g.addr[31:28])
                4'd0: mem_m[int'(g.addr[9:2])] = g.wdata;
                4'd1: begin
                    if (ofs == `SOC_TMR_VALUE_OFS)
                        m_value = g.wdata;
                    if (ofs == `SOC_TMR_CTRL_OFS) begin
                        m_en = g.wdata[0];
                        m_ie = g.wdata[1];
                        if (g.wdata[2] && !match)
                            m_pend = 1'b0;
                    end
                end
                4'd2: begin
                    if (ofs == `SOC_GPIO_CTRL_OFS)
                        m_ctrl = g.wdata;
                    if (ofs == `SOC_GPIO_DATA_OFS)
                        m_data = g.wdata[`SOC_GPIO_PINS-1:0];
                end
                default: ;
            endcase
        end
        m_sync2 = m_sync1;
        m_sync1 = gpio_i;
    endtask

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_count++;
        assert (got === exp) else begin
            err_count++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic soc_pkg::bus_req_t build_req(input logic we, input logic [31:0] addr,
                                                    input logic [31:0] wdata);
        soc_pkg::bus_req_t r;
        r.req   = 1'b1;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // inactive master still wiggles its other fields
    function automatic soc_pkg::bus_req_t idle_req();
        soc_pkg::bus_req_t r;
        r = build_req(1'($urandom), $urandom, $urandom);
        r.req = 1'b0;
        return r;
    endfunction

    function automatic logic [31:0] mem_addr(input int idx);
        return {4'h0, 18'($urandom), 8'(idx), 2'b00};
    endfunction

    function automatic int pick_written();
        return written_q[$urandom % written_q.size()];
    endfunction

    // entered on a falling edge, returns on the next one
    task automatic drive_cycle(input soc_pkg::bus_req_t r0, input soc_pkg::bus_req_t r1);
        logic [31:0] exp0;
        logic [31:0] exp1;
        bit          known0;
        bit          known1;
        m0_req = r0;
        m1_req = r1;
        gpio_i = `SOC_GPIO_PINS'($urandom);
        #1;
        exp0 = '0;
        exp1 = '0;
        known0 = 1'b1;
        known1 = 1'b1;
        if (r1.req)
            exp1 = expected_read(r1.addr, known1);
        else if (r0.req)
            exp0 = expected_read(r0.addr, known0);
        if (known0)
            check_value("m0_rdata_o", m0_rdata, exp0);
        if (known1)
            check_value("m1_rdata_o", m1_rdata, exp1);
        check_value("hold_o", 32'(hold), 32'(r0.req & r1.req));
        check_value("irq_o", 32'(irq), 32'(m_pend & m_ie));
        check_value("gpio_oe_o", 32'(gpio_oe), 32'(oe_expect()));
        check_value("gpio_out_o", 32'(gpio_out), 32'(m_data));
        @(posedge clk);
        advance_model();
        @(negedge clk);
    endtask

    // single access from a randomly chosen master
    task automatic access(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
        if ($urandom % 2 == 1)
            drive_cycle(idle_req(), build_req(we, addr, wdata));
        else
            drive_cycle(build_req(we, addr, wdata), idle_req());
    endtask

    task automatic wait_pending();
        int n;
        n = 0;
        while (!m_pend && n < 64) begin
            access(1'b0, TMR_COUNT, '0);
            n++;
        end
        assert (m_pend) else begin
            err_count++;
            $display("timer never reached its compare value within %0d cycles", n);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int          idx;
        logic [31:0] a;
        void'($urandom(32'hd4f4));
        err_count = 0;
        chk_count = 0;
        rst_n_i = 1'b0;
        m0_req = '0;
        m1_req = '0;
        gpio_i = '0;
        {m_en, m_ie, m_pend} = 3'b000;
        {m_count, m_value, m_ctrl} = '0;
        {m_data, m_sync1, m_sync2} = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // registers read back cleared
        access(1'b0, TMR_CTRL, '0);
        access(1'b0, TMR_COUNT, '0);
        access(1'b0, TMR_VALUE, '0);
        access(1'b0, GPIO_CTRL, '0);
        access(1'b0, GPIO_DATA, '0);

        // memory traffic, one master at a time
        repeat (N_MEM) begin
            if (written_q.size() == 0 || $urandom % 2 == 0) begin
                idx = int'($urandom % 256);
                if (!mem_m.exists(idx))
                    written_q.push_back(idx);
                access(1'b1, mem_addr(idx), $urandom);
            end else begin
                access(1'b0, mem_addr(pick_written()), '0);
            end
        end

        // both masters at once, the core write must be dropped
        repeat (N_CONFLICT) begin
            a = mem_addr(pick_written());
            drive_cycle(build_req(1'b1, a, $urandom),
                        build_req(1'($urandom), mem_addr(pick_written()), $urandom));
            access(1'b0, a, '0);
        end

        // unmapped select values
        repeat (N_UNMAP) begin
            idx = pick_written();
            a = {4'(3 + $urandom % 13), 18'($urandom), 8'(idx), 2'b00};
            access(1'b1, a, $urandom);
            access(1'b0, a, '0);
            access(1'b0, mem_addr(idx), '0);
        end

        // gpio modes, data and synchronized inputs
        repeat (N_GPIO) begin
            access(1'b1, GPIO_CTRL, $urandom);
            access(1'b1, GPIO_DATA, $urandom);
            repeat (16) access(1'b0, GPIO_DATA, '0);
        end

        // timer compare, pending clear, then stop
        repeat (N_TMR) begin
            access(1'b1, TMR_VALUE, 32'(2 + $urandom % 19));
            access(1'b1, TMR_CTRL, 32'h3);
            wait_pending();
            access(1'b1, TMR_CTRL, 32'h7);
            repeat (3) access(1'b0, TMR_COUNT, '0);
            wait_pending();
            access(1'b1, TMR_CTRL, 32'h4);
            access(1'b0, TMR_CTRL, '0);
        end

        $display("checks: %0d, errors: %0d", chk_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TOTAL_TXN + 200) * CLK_PERIOD);
        $display("watchdog expired before the test sequence completed");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/soc_pkg.sv
hw/soc_bus.sv
hw/data_mem.sv
hw/timer.sv
hw/gpio.sv
hw/soc_top.sv
test/tb_soc_top.sv

// File: Makefile
# verilator lint and simulation for the soc peripheral subsystem

VERILATOR  := verilator
TOP        := tb_soc_top
FILELIST   := verilog.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
SOURCES    := $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
